// ==== hdl/rtx_pkg.sv ====
package rtx_pkg;

  // fp24 layout: sign | 7-bit exponent | 16-bit mantissa, implicit leading one
  localparam int fp24_man_bits = 16;
  localparam int fp24_exp_bits = 7;
  localparam int fp24_exp_lsb = fp24_man_bits;
  localparam int fp24_sign_bit = fp24_man_bits + fp24_exp_bits;
  localparam int fp24_exp_bias = 63;

  typedef logic [fp24_sign_bit:0] fp24;
  typedef logic [fp24_exp_bits-1:0] fp24_exp_t;
  typedef logic [fp24_man_bits-1:0] fp24_man_t;

  localparam fp24 fp24_one = {1'b0, fp24_exp_t'(fp24_exp_bias), {fp24_man_bits{1'b0}}};

  // raster coordinates
  typedef logic [10:0] pixel_h_t;
  typedef logic [9:0] pixel_v_t;

  // integer ray component before conversion
  typedef logic signed [11:0] ray_int;

  // blue 15:11, green 10:5, red 4:0
  typedef logic [15:0] rgb565;

  typedef logic [3:0] floor_height_t;  // camera height above the floor

  typedef enum logic [1:0] {
    idle,
    shade,
    divide,
    done
  } tracer_state;

endpackage

// ==== hdl/make_fp24.sv ====
`default_nettype none

module make_fp24
  import rtx_pkg::*;
#(
  parameter int IN_WIDTH = 12
) (
  input  logic                       clk,
  input  logic signed [IN_WIDTH-1:0] n,
  output fp24                        x
);

  logic [IN_WIDTH-1:0] mag;
  int unsigned msb;
  logic [IN_WIDTH+fp24_man_bits-1:0] aligned;
  fp24_exp_t exp_field;

  always_comb begin
    mag = n[IN_WIDTH-1] ? -n : n;

    // position of the leading one
    msb = 0;
    for (int i = 0; i < IN_WIDTH; i++) begin
      if (mag[i])
        msb = i;
    end

    // leading one lands on bit fp24_man_bits and drops out
    aligned = {{fp24_man_bits{1'b0}}, mag} << (fp24_man_bits - msb);
    exp_field = fp24_exp_t'(fp24_exp_bias + msb);
  end

  always_ff @(posedge clk) begin
    if (mag == '0)
      x <= '0;  // zero has no leading one
    else
      x <= {n[IN_WIDTH-1], exp_field, aligned[fp24_man_bits-1:0]};
  end

endmodule

`default_nettype wire

// ==== hdl/convert_fp24_uint.sv ====
`default_nettype none

module convert_fp24_uint
  import rtx_pkg::*;
#(
  parameter int WIDTH = 5,
  parameter int FRAC = 4
) (
  input  logic             clk,
  input  fp24              x,
  output logic [WIDTH-1:0] n
);

  logic [fp24_man_bits:0] sig;
  int shift;
  logic [WIDTH-1:0] val;

  always_comb begin
    sig = {1'b1, fp24_man_t'(x[fp24_man_bits-1:0])};
    // integer bits kept above the binary point after scaling by 2^FRAC
    shift = int'(x[fp24_exp_lsb +: fp24_exp_bits]) - fp24_exp_bias + FRAC;

    if (x[fp24_sign_bit] || x == '0 || shift < 0)
      val = '0;  // negative or under one lsb
    else if (shift >= WIDTH)
      val = '1;  // saturate
    else
      val = WIDTH'(sig >> (fp24_man_bits - shift));
  end

  always_ff @(posedge clk) begin
    n <= val;
  end

endmodule

`default_nettype wire

// ==== hdl/ray_caster.sv ====
`default_nettype none

module ray_caster
  import rtx_pkg::*;
#(
  parameter int WIDTH = 1280,
  parameter int HEIGHT = 720
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     new_ray,
  output pixel_h_t pixel_h,
  output pixel_v_t pixel_v,
  output fp24      ray_dir_x,
  output fp24      ray_dir_y,
  output fp24      ray_dir_z,
  output logic     ray_valid
);

  ray_int dx;
  ray_int dy;
  ray_int dz;
  logic cast_valid;

  // parked on the last pixel so the first advance lands on (0,0)
  always_ff @(posedge clk) begin
    if (rst) begin
      pixel_h <= pixel_h_t'(WIDTH - 1);
      pixel_v <= pixel_v_t'(HEIGHT - 1);
    end else if (new_ray) begin
      if (pixel_h == pixel_h_t'(WIDTH - 1)) begin
        pixel_h <= '0;
        if (pixel_v == pixel_v_t'(HEIGHT - 1))
          pixel_v <= '0;
        else
          pixel_v <= pixel_v + 1'b1;
      end else begin
        pixel_h <= pixel_h + 1'b1;
      end
    end
  end

  // counter stage, then conversion stage
  always_ff @(posedge clk) begin
    if (rst) begin
      cast_valid <= 1'b0;
      ray_valid <= 1'b0;
    end else begin
      cast_valid <= new_ray;
      ray_valid <= cast_valid;
    end
  end

  // camera at the origin looking down +z, image plane one unit per pixel
  assign dx = ray_int'(pixel_h) - ray_int'(WIDTH / 2);
  assign dy = ray_int'(HEIGHT / 2) - ray_int'(pixel_v);
  assign dz = ray_int'(WIDTH);

  make_fp24 #(.IN_WIDTH($bits(ray_int))) dx_maker (
    .clk(clk),
    .n(dx),
    .x(ray_dir_x)
  );

  make_fp24 #(.IN_WIDTH($bits(ray_int))) dy_maker (
    .clk(clk),
    .n(dy),
    .x(ray_dir_y)
  );

  make_fp24 #(.IN_WIDTH($bits(ray_int))) dz_maker (
    .clk(clk),
    .n(dz),
    .x(ray_dir_z)
  );

endmodule

`default_nettype wire

// ==== hdl/ray_tracer.sv ====
`default_nettype none

module ray_tracer
  import rtx_pkg::*;
#(
  parameter int WIDTH = 1280,
  parameter int HEIGHT = 720
) (
  input  logic          clk,
  input  logic          rst,
  input  floor_height_t floor_height,
  input  pixel_h_t      pixel_h_in,
  input  pixel_v_t      pixel_v_in,
  input  fp24           ray_dir_x,
  input  fp24           ray_dir_y,
  input  fp24           ray_dir_z,
  input  logic          ray_valid,
  output logic          ray_done,
  output fp24           pixel_color_r,
  output fp24           pixel_color_g,
  output fp24           pixel_color_b,
  output pixel_h_t      pixel_h_out,
  output pixel_v_t      pixel_v_out
);

  localparam int STEPS = 16;
  localparam int MAG_W = $bits(ray_int);
  localparam int PROD_W = $bits(floor_height_t) + $clog2(WIDTH + 1);
  localparam int DIV_W = $clog2(HEIGHT / 2 + 1);  // |dy| never exceeds HEIGHT/2

  localparam fp24 col_half = fp24_one - (fp24'(1) << fp24_exp_lsb);
  localparam fp24 col_3q = col_half | (fp24'(1) << (fp24_exp_lsb - 1));
  localparam fp24 col_quarter = col_half - (fp24'(1) << fp24_exp_lsb);

  // exact for integer values, so a plain shift recovers the magnitude
  function automatic logic [MAG_W-1:0] fp24_mag(input fp24 v);
    logic [fp24_man_bits:0] sig;
    int e;
    sig = {1'b1, v[fp24_man_bits-1:0]};
    e = int'(v[fp24_exp_lsb +: fp24_exp_bits]) - fp24_exp_bias;
    if (v == '0 || e < 0)
      return '0;
    return MAG_W'(sig >> (fp24_man_bits - e));
  endfunction

  tracer_state state;

  logic dx_neg;
  fp24 dir_y;
  fp24 dir_z;
  floor_height_t fh;
  pixel_h_t h_q;
  pixel_v_t v_q;

  logic [STEPS-1:0] quot;
  logic [DIV_W-1:0] rem;
  logic [DIV_W-1:0] divisor;
  logic [$clog2(STEPS)-1:0] step;

  logic [MAG_W-1:0] dy_mag;
  logic [MAG_W-1:0] dz_mag;
  logic [PROD_W-1:0] prod;
  logic [DIV_W:0] trial;
  logic fits;

  assign dy_mag = fp24_mag(dir_y);
  assign dz_mag = fp24_mag(dir_z);
  assign prod = PROD_W'(fh) * PROD_W'(dz_mag);  // height times focal length
  assign trial = {rem, quot[STEPS-1]};
  assign fits = trial >= {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      ray_done <= 1'b0;
    end else begin
      ray_done <= 1'b0;
      case (state)
        idle: begin
          if (ray_valid)
            state <= shade;
        end
        shade: begin
          if (!dir_y[fp24_sign_bit]) begin  // looking up into the sky
            ray_done <= 1'b1;
            state <= idle;
          end else begin
            state <= divide;
          end
        end
        divide: begin
          if (step == $clog2(STEPS)'(STEPS - 1))
            state <= done;
        end
        done: begin
          ray_done <= 1'b1;
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (ray_valid) begin
          dx_neg <= ray_dir_x[fp24_sign_bit];
          dir_y <= ray_dir_y;
          dir_z <= ray_dir_z;
          fh <= floor_height;
          h_q <= pixel_h_in;
          v_q <= pixel_v_in;
        end
      end
      shade: begin
        // divider load
        quot <= STEPS'(prod);
        rem <= '0;
        divisor <= DIV_W'(dy_mag);
        step <= '0;
        if (!dir_y[fp24_sign_bit]) begin
          pixel_color_r <= col_half;
          pixel_color_g <= col_3q;
          pixel_color_b <= fp24_one;
          pixel_h_out <= h_q;
          pixel_v_out <= v_q;
        end
      end
      divide: begin
        // restoring step shifts the quotient in where the dividend shifts out
        step <= step + 1'b1;
        quot <= {quot[STEPS-2:0], fits};
        if (fits)
          rem <= DIV_W'(trial - {1'b0, divisor});
        else
          rem <= trial[DIV_W-1:0];
      end
      done: begin
        if (quot[2] == dx_neg) begin
          pixel_color_r <= fp24_one;
          pixel_color_g <= fp24_one;
          pixel_color_b <= fp24_one;
        end else begin
          pixel_color_r <= col_quarter;
          pixel_color_g <= col_quarter;
          pixel_color_b <= col_quarter;
        end
        pixel_h_out <= h_q;
        pixel_v_out <= v_q;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rtx.sv ====
`default_nettype none

module rtx
  import rtx_pkg::*;
#(
  parameter int WIDTH = 1280,
  parameter int HEIGHT = 720
) (
  input  logic          clk,
  input  logic          rst,
  input  floor_height_t floor_height,
  output rgb565         rtx_pixel,
  output pixel_h_t      pixel_h,
  output pixel_v_t      pixel_v,
  output logic          ray_done  // rtx_pixel valid
);

  logic rst_prev;
  logic new_ray;
  logic ray_done_raw;

  pixel_h_t cast_h;
  pixel_v_t cast_v;
  fp24 ray_dir_x;
  fp24 ray_dir_y;
  fp24 ray_dir_z;
  logic ray_valid;

  fp24 color_r;
  fp24 color_g;
  fp24 color_b;

  always_ff @(posedge clk) begin
    rst_prev <= rst;
  end

  // one ray in flight: next one starts on reset release or after a pixel leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      new_ray <= 1'b0;
      ray_done <= 1'b0;
    end else begin
      new_ray <= rst_prev | ray_done;
      ray_done <= ray_done_raw;  // lines up with the converter stage
    end
  end

  ray_caster #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) caster (
    .clk(clk),
    .rst(rst),
    .new_ray(new_ray),
    .pixel_h(cast_h),
    .pixel_v(cast_v),
    .ray_dir_x(ray_dir_x),
    .ray_dir_y(ray_dir_y),
    .ray_dir_z(ray_dir_z),
    .ray_valid(ray_valid)
  );

  ray_tracer #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) tracer (
    .clk(clk),
    .rst(rst),
    .floor_height(floor_height),
    .pixel_h_in(cast_h),
    .pixel_v_in(cast_v),
    .ray_dir_x(ray_dir_x),
    .ray_dir_y(ray_dir_y),
    .ray_dir_z(ray_dir_z),
    .ray_valid(ray_valid),
    .ray_done(ray_done_raw),
    .pixel_color_r(color_r),
    .pixel_color_g(color_g),
    .pixel_color_b(color_b),
    .pixel_h_out(pixel_h),
    .pixel_v_out(pixel_v)
  );

  // 565 packing
  convert_fp24_uint #(.WIDTH(5), .FRAC(4)) r_convert (
    .clk(clk),
    .x(color_r),
    .n(rtx_pixel[4:0])
  );

  convert_fp24_uint #(.WIDTH(6), .FRAC(5)) g_convert (
    .clk(clk),
    .x(color_g),
    .n(rtx_pixel[10:5])
  );

  convert_fp24_uint #(.WIDTH(5), .FRAC(5)) b_convert (
    .clk(clk),
    .x(color_b),
    .n(rtx_pixel[15:11])
  );

endmodule

`default_nettype wire

// ==== sim/rtx_sva.sv ====
module rtx_sva
  import rtx_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        ray_valid,
  input logic        ray_done,
  input tracer_state state
);

  int failures;  // read by the testbench

  initial failures = 0;

  done_pulse: assert property (@(posedge clk) disable iff (rst) ray_done |=> !ray_done)
    else begin
      $error("ray_done held high for more than one cycle");
      failures++;
    end

  // only one ray in flight, so a new one must find the tracer idle
  valid_in_idle: assert property (@(posedge clk) disable iff (rst) ray_valid |-> state == idle)
    else begin
      $error("ray_valid while tracer busy");
      failures++;
    end

  quiet_after_reset: assert property (@(posedge clk) rst |=> !ray_done && !ray_valid)
    else begin
      $error("strobe high after reset");
      failures++;
    end

endmodule

bind ray_tracer rtx_sva tracer_sva (
  .clk(clk),
  .rst(rst),
  .ray_valid(ray_valid),
  .ray_done(ray_done),
  .state(state)
);

// ==== sim/rtx_tb.sv ====
module rtx_tb
  import rtx_pkg::*;
;

  localparam int img_width = 32;
  localparam int img_height = 16;
  localparam int frame_pixels = img_width * img_height;
  localparam int mid_pixels = 200;  // reset lands here mid-frame
  localparam int total_pixels = 3 * frame_pixels + mid_pixels + frame_pixels + 40;
  localparam int watchdog_time = total_pixels * 25 * 20;

  logic clk;
  logic rst;
  floor_height_t floor_height;
  rgb565 rtx_pixel;
  pixel_h_t pixel_h;
  pixel_v_t pixel_v;
  logic ray_done;

  logic [15:0] lfsr;
  int exp_h;
  int exp_v;
  int fh_accepted;
  int arm;  // falling edges left until the tracer samples floor_height
  int gap;
  int pixels_seen;
  int sky_cnt;
  int light_cnt;
  int dark_cnt;
  int fh0_cnt;

  rtx #(.WIDTH(img_width), .HEIGHT(img_height)) i_rtx (
    .clk(clk),
    .rst(rst),
    .floor_height(floor_height),
    .rtx_pixel(rtx_pixel),
    .pixel_h(pixel_h),
    .pixel_v(pixel_v),
    .ray_done(ray_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out)
      lfsr = lfsr ^ 16'hB400;
    return out;
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
      v = (v << 1) | int'(lfsr_step());
    return v;
  endfunction

  // saturated floor(x * 2^frac) with x given in quarters
  function automatic int scale_channel(input int quarters, input int width, input int frac);
    int v;
    v = (quarters << frac) >> 2;
    if (v > (1 << width) - 1)
      v = (1 << width) - 1;
    return v;
  endfunction

  function automatic rgb565 pack_color(input int r_q, input int g_q, input int b_q);
    rgb565 p;
    p[4:0] = 5'(scale_channel(r_q, 5, 4));
    p[10:5] = 6'(scale_channel(g_q, 6, 5));
    p[15:11] = 5'(scale_channel(b_q, 5, 5));
    return p;
  endfunction

  function automatic rgb565 model_pixel(input int h, input int v, input int fh);
    int dx;
    int dy;
    int q;
    dx = h - img_width / 2;
    dy = img_height / 2 - v;
    if (dy >= 0)
      return pack_color(2, 3, 4);  // sky
    q = fh * img_width / (-dy);
    if (((q >> 2) & 1) == ((dx < 0) ? 1 : 0))
      return pack_color(4, 4, 4);
    return pack_color(1, 1, 1);
  endfunction

  task automatic check_pixel(input rgb565 exp_val, input rgb565 got);
    if (got !== exp_val) begin
      $display("ERR rtx_pixel exp %h got %h", exp_val, got);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_h(input pixel_h_t exp_val, input pixel_h_t got);
    if (got !== exp_val) begin
      $display("ERR pixel_h exp %h got %h", exp_val, got);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_v(input pixel_v_t exp_val, input pixel_v_t got);
    if (got !== exp_val) begin
      $display("ERR pixel_v exp %h got %h", exp_val, got);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_gap(input int exp_val, input int got);
    if (got != exp_val) begin
      $display("ERR ray_done_gap exp %h got %h", exp_val, got);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_result();
    rgb565 want;
    want = model_pixel(exp_h, exp_v, fh_accepted);
    check_h(pixel_h_t'(exp_h), pixel_h);
    check_v(pixel_v_t'(exp_v), pixel_v);
    check_pixel(want, rtx_pixel);
    check_gap((exp_v <= img_height / 2) ? 6 : 23, gap);
    if (exp_v <= img_height / 2) begin
      sky_cnt++;
    end else begin
      if (want == pack_color(4, 4, 4))
        light_cnt++;
      else
        dark_cnt++;
      if (fh_accepted == 0)
        fh0_cnt++;
    end
    exp_h++;
    if (exp_h == img_width) begin
      exp_h = 0;
      exp_v = (exp_v + 1) % img_height;
    end
  endtask

  // sample outputs and then drive inputs on one falling edge
  task automatic tick();
    @(negedge clk);
    if (i_rtx.tracer.tracer_sva.failures != 0)
      fail_now("an assertion in the ray tracer failed");
    gap++;
    if (ray_done === 1'b1)
      check_result();
    if (draw_bits(3) == 0)
      floor_height = floor_height_t'(draw_bits(4));
    if (arm > 0) begin
      arm--;
      if (arm == 0)
        fh_accepted = int'(floor_height);
    end
    if (ray_done === 1'b1) begin
      arm = 3;
      gap = 0;
      pixels_seen++;
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) begin
      @(negedge clk);
      if (ray_done !== 1'b0)
        fail_now("ray_done was not low while reset was held");
    end
    rst = 1'b0;
    exp_h = 0;
    exp_v = 0;
    gap = 0;
    arm = 3;  // first ray is accepted like one following a ray_done
  endtask

  task automatic run_pixels(input int n);
    int target;
    target = pixels_seen + n;
    while (pixels_seen < target)
      tick();
  endtask

  initial begin
    #(watchdog_time);
    $display("no pixel stream finished in time");
    $display("sim failed");
    $fatal(1);
  end

  initial begin
    rst = 1'b1;
    floor_height = '0;
    lfsr = 16'd49569;
    fh_accepted = 0;
    pixels_seen = 0;
    sky_cnt = 0;
    light_cnt = 0;
    dark_cnt = 0;
    fh0_cnt = 0;
    apply_reset();
    run_pixels(3 * frame_pixels);
    run_pixels(mid_pixels);
    repeat (5) tick();  // next sky ray has its ray_done_raw high when reset hits
    apply_reset();
    run_pixels(frame_pixels + 40);
    if (sky_cnt == 0 || light_cnt == 0 || dark_cnt == 0 || fh0_cnt == 0)
      fail_now("some pixel kinds never appeared in the stream");
    if (i_rtx.tracer.tracer_sva.failures == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("sim failed");
      $fatal(1);
    end
  end

endmodule

// ==== flist.f ====
hdl/rtx_pkg.sv
hdl/make_fp24.sv
hdl/convert_fp24_uint.sv
hdl/ray_caster.sv
hdl/ray_tracer.sv
hdl/rtx.sv
sim/rtx_sva.sv
sim/rtx_tb.sv
